//--- rt_fixed_pkg.sv
package rt_fixed_pkg;

  // signed Q16.16
  typedef logic signed [31:0] fp;

  localparam int FRAC_BITS = 16;
  localparam fp FP_ZERO = 32'sh0000_0000;
  localparam fp FP_ONE = 32'sh0001_0000;
  localparam fp FP_THREE = 32'sh0003_0000;

  function automatic fp fp_mul(input fp a, input fp b);
    logic signed [63:0] wide_a;
    logic signed [63:0] wide_b;
    logic signed [63:0] prod;
    wide_a = a;
    wide_b = b;
    prod = wide_a * wide_b;
    // keep the middle 32 bits, same as an arithmetic shift by FRAC_BITS
    return prod[FRAC_BITS +: 32];
  endfunction

  function automatic fp fp_add(input fp a, input fp b);
    return a + b;
  endfunction

  function automatic fp fp_sub(input fp a, input fp b);
    return a - b;
  endfunction

  function automatic fp fp_neg(input fp a);
    return -a;
  endfunction

  function automatic fp fp_dot3(input fp ax, input fp ay, input fp az,
                                input fp bx, input fp by, input fp bz);
    return fp_add(fp_add(fp_mul(ax, bx), fp_mul(ay, by)), fp_mul(az, bz));
  endfunction

  // power-of-two estimate of 1/sqrt(a)
  function automatic fp fp_isqrt_seed(input fp a);
    int lead;
    int half;
    fp seed;
    lead = FRAC_BITS;
    for (int i = 0; i < 31; i++) begin
      if (a[i]) begin
        lead = i;
      end
    end
    // exponent rounded up, so a*seed*seed lands in [0.5, 2)
    half = (lead - FRAC_BITS + 1) >>> 1;
    seed = 32'sd1 <<< (FRAC_BITS - half);
    if (a <= FP_ZERO) begin
      seed = FP_ONE;
    end
    return seed;
  endfunction

  // one Newton step: y * (3 - a*y*y) / 2
  function automatic fp fp_isqrt_step(input fp a, input fp y);
    fp ay;
    fp ayy;
    fp corr;
    ay = fp_mul(a, y);
    ayy = fp_mul(ay, y);
    corr = fp_sub(FP_THREE, ayy);
    return fp_mul(y, corr) >>> 1;
  endfunction

endpackage

//--- rt_frame_pkg.sv
package rt_frame_pkg;
  import rt_fixed_pkg::*;

  localparam int DISPLAY_WIDTH = 16;
  localparam int DISPLAY_HEIGHT = 12;
  localparam int H_BITS = 4;
  localparam int V_BITS = 4;

  localparam fp FP_DISPLAY_WIDTH = DISPLAY_WIDTH * FP_ONE;
  localparam fp FP_DISPLAY_HEIGHT = DISPLAY_HEIGHT * FP_ONE;
  localparam fp FP_INV_DISPLAY_HEIGHT = FP_ONE / DISPLAY_HEIGHT;

  // buffer depth doubles as the credit count
  localparam int BUF_DEPTH = 4;
  localparam int BUF_PTR_BITS = $clog2(BUF_DEPTH);
  localparam int CREDIT_BITS = $clog2(BUF_DEPTH + 1);
  localparam int ISQRT_ITERS = 4;
  localparam int ISQ_CNT_BITS = $clog2(ISQRT_ITERS + 1);

  localparam int SKY_BASE = 128;
  localparam logic [7:0] GROUND_DARK = 8'd40;
  localparam logic [7:0] GROUND_LIGHT = 8'd80;

  typedef enum logic [3:0] {
    GEN_IDLE, GEN_RIGHT, GEN_UP, GEN_SCREEN, GEN_SCALE,
    GEN_SUM, GEN_NORM, GEN_OUTPUT, GEN_SEND
  } gen_state_t;

  typedef enum logic [1:0] {ISQ_IDLE, ISQ_ITER, ISQ_DONE} isqrt_state_t;

endpackage

//--- fp_inv_sqrt.sv
`timescale 1ns/1ps

module fp_inv_sqrt
  import rt_fixed_pkg::*;
  import rt_frame_pkg::*;
(
  input  logic clk_in,
  input  logic rst_in,
  input  logic isq_start,
  input  fp    isq_a,
  output logic isq_done,
  output fp    isq_result
);

  isqrt_state_t state;
  logic [ISQ_CNT_BITS-1:0] iter_cnt;
  fp a_reg;
  fp y_reg;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= ISQ_IDLE;
      iter_cnt <= '0;
    end else begin
      case (state)
        ISQ_IDLE: begin
          if (isq_start) begin
            iter_cnt <= '0;
            state <= ISQ_ITER;
          end
        end
        ISQ_ITER: begin
          iter_cnt <= iter_cnt + 1'b1;
          if (iter_cnt == ISQ_CNT_BITS'(ISQRT_ITERS - 1)) begin
            state <= ISQ_DONE;
          end
        end
        default: state <= ISQ_IDLE;
      endcase
    end
  end

  // operand and estimate, one Newton step per cycle on the same multipliers
  always_ff @(posedge clk_in) begin
    if (state == ISQ_IDLE && isq_start) begin
      a_reg <= isq_a;
      y_reg <= fp_isqrt_seed(isq_a);
    end else if (state == ISQ_ITER) begin
      y_reg <= fp_isqrt_step(a_reg, y_reg);
    end
  end

  assign isq_done = (state == ISQ_DONE);
  assign isq_result = y_reg;

  // the generator keeps only one root in flight
  a_start_idle: assert property (@(posedge clk_in) disable iff (rst_in)
    isq_start |-> state == ISQ_IDLE);

endmodule

//--- pixel_scanner.sv
`timescale 1ns/1ps

module pixel_scanner
  import rt_frame_pkg::*;
(
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              start,
  input  logic              pix_ready,
  output logic              pix_valid,
  output logic [H_BITS-1:0] pix_h,
  output logic [V_BITS-1:0] pix_v,
  output logic              busy
);

  logic last_col;
  logic last_row;

  assign last_col = (pix_h == H_BITS'(DISPLAY_WIDTH - 1));
  assign last_row = (pix_v == V_BITS'(DISPLAY_HEIGHT - 1));

  // a coordinate is on offer for the whole frame
  assign pix_valid = busy;

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      busy <= 1'b0;
      pix_h <= '0;
      pix_v <= '0;
    end else if (!busy) begin
      if (start) begin
        busy <= 1'b1;
        pix_h <= '0;
        pix_v <= '0;
      end
    end else if (pix_ready) begin
      if (last_col) begin
        pix_h <= '0;
        if (last_row) begin
          busy <= 1'b0;
        end else begin
          pix_v <= pix_v + 1'b1;
        end
      end else begin
        pix_h <= pix_h + 1'b1;
      end
    end
  end

endmodule

//--- ray_generator.sv
`timescale 1ns/1ps

module ray_generator
  import rt_fixed_pkg::*;
  import rt_frame_pkg::*;
(
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              pix_valid,
  input  logic [H_BITS-1:0] pix_h,
  input  logic [V_BITS-1:0] pix_v,
  output logic              pix_ready,
  input  fp                 cam_x,
  input  fp                 cam_y,
  input  fp                 cam_z,
  output logic              ray_push,
  output logic [H_BITS-1:0] ray_h,
  output logic [V_BITS-1:0] ray_v,
  output fp                 ray_x,
  output fp                 ray_y,
  output fp                 ray_z,
  input  logic              credit_return
);

  gen_state_t state;
  logic [CREDIT_BITS-1:0] credits;

  fp h_fp;
  fp v_fp;
  fp fwd_x, fwd_y, fwd_z;
  fp right_x, right_z;
  fp up_x, up_y, up_z;
  fp px, py;
  fp sr_x, sr_z;
  fp su_x, su_y, su_z;
  fp d_x, d_y, d_z;

  logic isq_start;
  fp isq_a;
  logic isq_done;
  fp isq_result;

  fp mul1_a, mul1_b, mul1_res;
  fp mul2_a, mul2_b, mul2_res;
  fp mul3_a, mul3_b, mul3_res;

  fp_inv_sqrt u_isqrt (
    .clk_in    (clk_in),
    .rst_in    (rst_in),
    .isq_start (isq_start),
    .isq_a     (isq_a),
    .isq_done  (isq_done),
    .isq_result(isq_result)
  );

  assign pix_ready = (state == GEN_IDLE);
  assign ray_push = (state == GEN_SEND) && (credits != '0);
  assign isq_start = (state == GEN_NORM);
  assign isq_a = fp_dot3(d_x, d_y, d_z, d_x, d_y, d_z);

  // three multipliers shared by SCREEN, SCALE and OUTPUT
  assign mul1_res = fp_mul(mul1_a, mul1_b);
  assign mul2_res = fp_mul(mul2_a, mul2_b);
  assign mul3_res = fp_mul(mul3_a, mul3_b);

  always_comb begin
    mul1_a = FP_ZERO;
    mul1_b = FP_ZERO;
    mul2_a = FP_ZERO;
    mul2_b = FP_ZERO;
    mul3_a = FP_ZERO;
    mul3_b = FP_ZERO;
    case (state)
      GEN_SCREEN: begin
        mul1_a = fp_sub(h_fp, FP_DISPLAY_WIDTH);
        mul1_b = FP_INV_DISPLAY_HEIGHT;
        mul2_a = fp_sub(v_fp, FP_DISPLAY_HEIGHT);
        mul2_b = FP_INV_DISPLAY_HEIGHT;
      end
      GEN_SCALE: begin
        mul1_a = right_x;
        mul1_b = px;
        mul3_a = right_z;
        mul3_b = px;
      end
      GEN_OUTPUT: begin
        mul1_a = d_x;
        mul1_b = isq_result;
        mul2_a = d_y;
        mul2_b = isq_result;
        mul3_a = d_z;
        mul3_b = isq_result;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      state <= GEN_IDLE;
    end else begin
      case (state)
        GEN_IDLE: begin
          if (pix_valid) begin
            state <= GEN_RIGHT;
          end
        end
        GEN_RIGHT: state <= GEN_UP;
        GEN_UP: state <= GEN_SCREEN;
        GEN_SCREEN: state <= GEN_SCALE;
        GEN_SCALE: state <= GEN_SUM;
        GEN_SUM: state <= GEN_NORM;
        GEN_NORM: state <= GEN_OUTPUT;
        GEN_OUTPUT: begin
          if (isq_done) begin
            state <= GEN_SEND;
          end
        end
        GEN_SEND: begin
          if (ray_push) begin
            state <= GEN_IDLE;
          end
        end
        default: state <= GEN_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_in) begin
    case (state)
      GEN_IDLE: begin
        if (pix_valid) begin
          ray_h <= pix_h;
          ray_v <= pix_v;
          fwd_x <= cam_x;
          fwd_y <= cam_y;
          fwd_z <= cam_z;
          // 2h and 2v in fp
          h_fp <= {{(31 - FRAC_BITS - H_BITS){1'b0}}, pix_h, 1'b0, {FRAC_BITS{1'b0}}};
          v_fp <= {{(31 - FRAC_BITS - V_BITS){1'b0}}, pix_v, 1'b0, {FRAC_BITS{1'b0}}};
        end
      end
      GEN_RIGHT: begin
        // (0,1,0) x fwd reduces to (fz, 0, -fx)
        right_x <= fwd_z;
        right_z <= fp_neg(fwd_x);
      end
      GEN_UP: begin
        up_x <= fp_mul(fwd_y, right_z);
        up_y <= fp_sub(fp_mul(fwd_z, right_x), fp_mul(fwd_x, right_z));
        up_z <= fp_neg(fp_mul(fwd_y, right_x));
      end
      GEN_SCREEN: begin
        px <= mul1_res;
        py <= mul2_res;
      end
      GEN_SCALE: begin
        sr_x <= mul1_res;
        sr_z <= mul3_res;
        su_x <= fp_mul(up_x, py);
        su_y <= fp_mul(up_y, py);
        su_z <= fp_mul(up_z, py);
      end
      GEN_SUM: begin
        d_x <= fp_add(fp_add(sr_x, su_x), fwd_x);
        d_y <= fp_add(su_y, fwd_y);
        d_z <= fp_add(fp_add(sr_z, su_z), fwd_z);
      end
      GEN_OUTPUT: begin
        // screen y grows downward
        if (isq_done) begin
          ray_x <= mul1_res;
          ray_y <= fp_neg(mul2_res);
          ray_z <= mul3_res;
        end
      end
      default: ;
    endcase
  end

  // one credit per free buffer slot
  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      credits <= CREDIT_BITS'(BUF_DEPTH);
    end else begin
      credits <= credits - CREDIT_BITS'(ray_push) + CREDIT_BITS'(credit_return);
    end
  end

  a_credit_bound: assert property (@(posedge clk_in) disable iff (rst_in)
    credits <= CREDIT_BITS'(BUF_DEPTH));

endmodule

//--- ray_buffer.sv
`timescale 1ns/1ps

module ray_buffer
  import rt_fixed_pkg::*;
  import rt_frame_pkg::*;
(
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              ray_push,
  input  logic [H_BITS-1:0] ray_h,
  input  logic [V_BITS-1:0] ray_v,
  input  fp                 ray_x,
  input  fp                 ray_y,
  input  fp                 ray_z,
  output logic              rd_valid,
  output logic [H_BITS-1:0] rd_h,
  output logic [V_BITS-1:0] rd_v,
  output fp                 rd_x,
  output fp                 rd_y,
  output fp                 rd_z,
  input  logic              rd_pop,
  output logic              credit_return
);

  logic [H_BITS-1:0] mem_h [BUF_DEPTH];
  logic [V_BITS-1:0] mem_v [BUF_DEPTH];
  fp mem_x [BUF_DEPTH];
  fp mem_y [BUF_DEPTH];
  fp mem_z [BUF_DEPTH];

  logic [BUF_PTR_BITS-1:0] wr_ptr;
  logic [BUF_PTR_BITS-1:0] rd_ptr;
  logic [CREDIT_BITS-1:0] count;

  always_ff @(posedge clk_in) begin
    if (ray_push) begin
      mem_h[wr_ptr] <= ray_h;
      mem_v[wr_ptr] <= ray_v;
      mem_x[wr_ptr] <= ray_x;
      mem_y[wr_ptr] <= ray_y;
      mem_z[wr_ptr] <= ray_z;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      credit_return <= 1'b0;
    end else begin
      wr_ptr <= wr_ptr + BUF_PTR_BITS'(ray_push);
      rd_ptr <= rd_ptr + BUF_PTR_BITS'(rd_pop);
      count <= count + CREDIT_BITS'(ray_push) - CREDIT_BITS'(rd_pop);
      // slot freed, hand the credit back
      credit_return <= rd_pop;
    end
  end

  assign rd_valid = (count != '0);
  assign rd_h = mem_h[rd_ptr];
  assign rd_v = mem_v[rd_ptr];
  assign rd_x = mem_x[rd_ptr];
  assign rd_y = mem_y[rd_ptr];
  assign rd_z = mem_z[rd_ptr];

  // credits upstream must keep a full buffer from being pushed
  a_no_overflow: assert property (@(posedge clk_in) disable iff (rst_in)
    ray_push |-> count != CREDIT_BITS'(BUF_DEPTH));

  a_no_underflow: assert property (@(posedge clk_in) disable iff (rst_in)
    rd_pop |-> rd_valid);

endmodule

//--- sky_shader.sv
`timescale 1ns/1ps

module sky_shader
  import rt_fixed_pkg::*;
  import rt_frame_pkg::*;
(
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              rd_valid,
  input  logic [H_BITS-1:0] rd_h,
  input  logic [V_BITS-1:0] rd_v,
  input  fp                 rd_y,
  output logic              rd_pop,
  input  logic              pixel_ready,
  output logic              pixel_valid,
  output logic [H_BITS-1:0] pixel_h,
  output logic [V_BITS-1:0] pixel_v,
  output logic [7:0]        pixel_shade,
  output logic              pixel_last
);

  fp sky_sum;
  logic [7:0] shade;
  logic last;

  // sky brightens toward zenith, ground is a 2x2 checkerboard
  assign sky_sum = SKY_BASE + (rd_y >>> 9);
  assign shade = !rd_y[31] ? ((sky_sum > 255) ? 8'd255 : sky_sum[7:0])
               : ((rd_h[1] ^ rd_v[1]) ? GROUND_LIGHT : GROUND_DARK);
  assign last = (rd_h == H_BITS'(DISPLAY_WIDTH - 1)) && (rd_v == V_BITS'(DISPLAY_HEIGHT - 1));

  // take a ray when the output slot is free or draining
  assign rd_pop = rd_valid && (!pixel_valid || pixel_ready);

  always_ff @(posedge clk_in) begin
    if (rst_in) begin
      pixel_valid <= 1'b0;
    end else if (rd_pop) begin
      pixel_valid <= 1'b1;
    end else if (pixel_ready) begin
      pixel_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk_in) begin
    if (rd_pop) begin
      pixel_h <= rd_h;
      pixel_v <= rd_v;
      pixel_shade <= shade;
      pixel_last <= last;
    end
  end

endmodule

//--- ray_top.sv
`timescale 1ns/1ps

module ray_top
  import rt_fixed_pkg::*;
  import rt_frame_pkg::*;
(
  input  logic              clk_in,
  input  logic              rst_in,
  input  logic              start,
  input  fp                 cam_x,
  input  fp                 cam_y,
  input  fp                 cam_z,
  input  logic              pixel_ready,
  output logic              busy,
  output logic              pixel_valid,
  output logic [H_BITS-1:0] pixel_h,
  output logic [V_BITS-1:0] pixel_v,
  output logic [7:0]        pixel_shade,
  output logic              pixel_last
);

  logic pix_valid;
  logic pix_ready;
  logic [H_BITS-1:0] pix_h;
  logic [V_BITS-1:0] pix_v;

  logic ray_push;
  logic [H_BITS-1:0] ray_h;
  logic [V_BITS-1:0] ray_v;
  fp ray_x, ray_y, ray_z;
  logic credit_return;

  logic rd_valid;
  logic rd_pop;
  logic [H_BITS-1:0] rd_h;
  logic [V_BITS-1:0] rd_v;
  fp rd_y;

  pixel_scanner u_scanner (
    .clk_in   (clk_in),
    .rst_in   (rst_in),
    .start    (start),
    .pix_ready(pix_ready),
    .pix_valid(pix_valid),
    .pix_h    (pix_h),
    .pix_v    (pix_v),
    .busy     (busy)
  );

  ray_generator u_generator (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .pix_valid    (pix_valid),
    .pix_h        (pix_h),
    .pix_v        (pix_v),
    .pix_ready    (pix_ready),
    .cam_x        (cam_x),
    .cam_y        (cam_y),
    .cam_z        (cam_z),
    .ray_push     (ray_push),
    .ray_h        (ray_h),
    .ray_v        (ray_v),
    .ray_x        (ray_x),
    .ray_y        (ray_y),
    .ray_z        (ray_z),
    .credit_return(credit_return)
  );

  // x and z of the head ray are not needed for shading
  ray_buffer u_buffer (
    .clk_in       (clk_in),
    .rst_in       (rst_in),
    .ray_push     (ray_push),
    .ray_h        (ray_h),
    .ray_v        (ray_v),
    .ray_x        (ray_x),
    .ray_y        (ray_y),
    .ray_z        (ray_z),
    .rd_valid     (rd_valid),
    .rd_h         (rd_h),
    .rd_v         (rd_v),
    .rd_x         (),
    .rd_y         (rd_y),
    .rd_z         (),
    .rd_pop       (rd_pop),
    .credit_return(credit_return)
  );

  sky_shader u_shader (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .rd_valid   (rd_valid),
    .rd_h       (rd_h),
    .rd_v       (rd_v),
    .rd_y       (rd_y),
    .rd_pop     (rd_pop),
    .pixel_ready(pixel_ready),
    .pixel_valid(pixel_valid),
    .pixel_h    (pixel_h),
    .pixel_v    (pixel_v),
    .pixel_shade(pixel_shade),
    .pixel_last (pixel_last)
  );

endmodule

//--- tb_ray_top.sv
`timescale 1ns/1ps

module tb_ray_top
  import rt_fixed_pkg::*;
  import rt_frame_pkg::*;
();

  localparam int FRAMES = 4;
  localparam int PIXELS = DISPLAY_WIDTH * DISPLAY_HEIGHT;
  localparam int CYCLE_LIMIT = FRAMES * PIXELS * (11 + ISQRT_ITERS) * 4;

  logic              clk_in;
  logic              rst_in;
  logic              start;
  fp                 cam_x;
  fp                 cam_y;
  fp                 cam_z;
  logic              pixel_ready;
  logic              busy;
  logic              pixel_valid;
  logic [H_BITS-1:0] pixel_h;
  logic [V_BITS-1:0] pixel_v;
  logic [7:0]        pixel_shade;
  logic              pixel_last;

  integer seed;
  int cycle_cnt;
  int frame_idx;

  // expected pixels of the running frame, raster order
  logic [H_BITS-1:0] exp_h_q[$];
  logic [V_BITS-1:0] exp_v_q[$];
  logic [7:0]        exp_shade_q[$];
  logic              exp_last_q[$];

  // output seen on the last stalled cycle
  logic              stalled;
  logic [H_BITS-1:0] held_h;
  logic [V_BITS-1:0] held_v;
  logic [7:0]        held_shade;
  logic              held_last;

  ray_top dut (
    .clk_in     (clk_in),
    .rst_in     (rst_in),
    .start      (start),
    .cam_x      (cam_x),
    .cam_y      (cam_y),
    .cam_z      (cam_z),
    .pixel_ready(pixel_ready),
    .busy       (busy),
    .pixel_valid(pixel_valid),
    .pixel_h    (pixel_h),
    .pixel_v    (pixel_v),
    .pixel_shade(pixel_shade),
    .pixel_last (pixel_last)
  );

  initial begin
    clk_in = 1'b0;
    forever #10 clk_in = ~clk_in;
  end

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string name, input int expected, input int actual);
    report_failure($sformatf("Mismatch %s: expected %0d, actual %0d", name, expected, actual));
  endtask

  function automatic void cross3(input fp ax, input fp ay, input fp az,
                                 input fp bx, input fp by, input fp bz,
                                 output fp cx, output fp cy, output fp cz);
    cx = fp_sub(fp_mul(ay, bz), fp_mul(az, by));
    cy = fp_sub(fp_mul(az, bx), fp_mul(ax, bz));
    cz = fp_sub(fp_mul(ax, by), fp_mul(ay, bx));
  endfunction

  // reference shade for one pixel and camera
  function automatic logic [7:0] model_shade(input int h, input int v,
                                             input fp fx, input fp fy, input fp fz);
    fp r_x, r_y, r_z;
    fp u_x, u_y, u_z;
    fp px, py;
    fp d_x, d_y, d_z;
    fp a;
    fp inv;
    fp ray_y;
    int sky;
    cross3(FP_ZERO, FP_ONE, FP_ZERO, fx, fy, fz, r_x, r_y, r_z);
    cross3(fx, fy, fz, r_x, r_y, r_z, u_x, u_y, u_z);
    px = fp_mul((2 * h - DISPLAY_WIDTH) * FP_ONE, FP_INV_DISPLAY_HEIGHT);
    py = fp_mul((2 * v - DISPLAY_HEIGHT) * FP_ONE, FP_INV_DISPLAY_HEIGHT);
    d_x = fp_add(fp_add(fp_mul(r_x, px), fp_mul(u_x, py)), fx);
    d_y = fp_add(fp_add(fp_mul(r_y, px), fp_mul(u_y, py)), fy);
    d_z = fp_add(fp_add(fp_mul(r_z, px), fp_mul(u_z, py)), fz);
    a = fp_dot3(d_x, d_y, d_z, d_x, d_y, d_z);
    inv = fp_isqrt_seed(a);
    for (int i = 0; i < ISQRT_ITERS; i++) begin
      inv = fp_isqrt_step(a, inv);
    end
    // image rows run downward
    ray_y = fp_neg(fp_mul(d_y, inv));
    if (ray_y >= 0) begin
      sky = SKY_BASE + int'(ray_y >>> 9);
      return (sky > 255) ? 8'd255 : 8'(sky);
    end
    return ((h / 2) % 2 != (v / 2) % 2) ? GROUND_LIGHT : GROUND_DARK;
  endfunction

  task automatic check_pixel();
    assert (exp_h_q.size() != 0)
      else report_failure($sformatf("frame %0d produced a pixel when none was expected",
                                    frame_idx));
    assert (pixel_h == exp_h_q[0])
      else report_mismatch($sformatf("frame %0d h", frame_idx), int'(exp_h_q[0]),
                           int'(pixel_h));
    assert (pixel_v == exp_v_q[0])
      else report_mismatch($sformatf("frame %0d v", frame_idx), int'(exp_v_q[0]),
                           int'(pixel_v));
    assert (pixel_shade == exp_shade_q[0])
      else report_mismatch($sformatf("frame %0d shade", frame_idx), int'(exp_shade_q[0]),
                           int'(pixel_shade));
    assert (pixel_last == exp_last_q[0])
      else report_mismatch($sformatf("frame %0d last", frame_idx), int'(exp_last_q[0]),
                           int'(pixel_last));
    void'(exp_h_q.pop_front());
    void'(exp_v_q.pop_front());
    void'(exp_shade_q.pop_front());
    void'(exp_last_q.pop_front());
  endtask

  // sink side, runs once per falling edge
  task automatic service_sink();
    logic rdy;
    if (stalled) begin
      assert (pixel_valid)
        else report_failure("pixel_valid dropped before the pixel was accepted");
      assert (pixel_h == held_h)
        else report_mismatch("hold h", int'(held_h), int'(pixel_h));
      assert (pixel_v == held_v)
        else report_mismatch("hold v", int'(held_v), int'(pixel_v));
      assert (pixel_shade == held_shade)
        else report_mismatch("hold shade", int'(held_shade), int'(pixel_shade));
      assert (pixel_last == held_last)
        else report_mismatch("hold last", int'(held_last), int'(pixel_last));
    end
    // roughly 30% of cycles stall
    rdy = ($unsigned($random(seed)) % 100) >= 30;
    pixel_ready = rdy;
    if (pixel_valid && rdy) begin
      check_pixel();
    end
    stalled = pixel_valid && !rdy;
    held_h = pixel_h;
    held_v = pixel_v;
    held_shade = pixel_shade;
    held_last = pixel_last;
  endtask

  task automatic step_cycle();
    @(negedge clk_in);
    cycle_cnt++;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      report_failure($sformatf("run timed out after %0d cycles", cycle_cnt));
    end
    service_sink();
  endtask

  task automatic run_frame();
    cam_x = $random(seed) % 32769;
    cam_y = $random(seed) % 32769;
    cam_z = FP_ONE;
    for (int v = 0; v < DISPLAY_HEIGHT; v++) begin
      for (int h = 0; h < DISPLAY_WIDTH; h++) begin
        exp_h_q.push_back(H_BITS'(h));
        exp_v_q.push_back(V_BITS'(v));
        exp_shade_q.push_back(model_shade(h, v, cam_x, cam_y, cam_z));
        exp_last_q.push_back(h == DISPLAY_WIDTH - 1 && v == DISPLAY_HEIGHT - 1);
      end
    end
    start = 1'b1;
    step_cycle();
    start = 1'b0;
    assert (busy) else report_failure("busy did not rise after the start pulse");
    // a second start mid-frame must be ignored
    repeat (3) step_cycle();
    start = 1'b1;
    step_cycle();
    start = 1'b0;
    while (exp_h_q.size() != 0) begin
      step_cycle();
    end
    assert (!busy) else report_failure("busy stayed high after the last pixel of the frame");
  endtask

  initial begin
    seed = 32'h27da_7e10;
    cycle_cnt = 0;
    frame_idx = 0;
    rst_in = 1'b1;
    start = 1'b0;
    cam_x = FP_ZERO;
    cam_y = FP_ZERO;
    cam_z = FP_ONE;
    pixel_ready = 1'b0;
    stalled = 1'b0;
    held_h = '0;
    held_v = '0;
    held_shade = '0;
    held_last = 1'b0;
    repeat (2) @(negedge clk_in);
    rst_in = 1'b0;
    assert (!pixel_valid) else report_failure("pixel_valid was high right after reset");
    assert (!busy) else report_failure("busy was high right after reset");
    for (frame_idx = 0; frame_idx < FRAMES; frame_idx++) begin
      run_frame();
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

//--- list.f
rt_fixed_pkg.sv
rt_frame_pkg.sv
fp_inv_sqrt.sv
pixel_scanner.sv
ray_generator.sv
ray_buffer.sv
sky_shader.sv
ray_top.sv
tb_ray_top.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the ray front-end testbench with Verilator.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_ray_top -f list.f

output=$(./obj_dir/Vtb_ray_top 2>&1) || true
printf '%s\n' "$output"

# pass only when the testbench printed its pass line
printf '%s\n' "$output" | grep -qx "Result: PASSED"
